// ==== rv_decode_pkg.sv ====
package rv_decode_pkg;

  localparam int xlen       = 64;
  localparam int ilen       = 32;
  localparam int reg_addr_w = 5;

  // RV64I major opcodes
  localparam logic [6:0] opc_load     = 7'b0000011;
  localparam logic [6:0] opc_op_imm   = 7'b0010011;
  localparam logic [6:0] opc_auipc    = 7'b0010111;
  localparam logic [6:0] opc_op_imm32 = 7'b0011011;
  localparam logic [6:0] opc_store    = 7'b0100011;
  localparam logic [6:0] opc_op       = 7'b0110011;
  localparam logic [6:0] opc_lui      = 7'b0110111;
  localparam logic [6:0] opc_op32     = 7'b0111011;
  localparam logic [6:0] opc_branch   = 7'b1100011;
  localparam logic [6:0] opc_jalr     = 7'b1100111;
  localparam logic [6:0] opc_jal      = 7'b1101111;

  // funct7 / funct6 patterns, alt selects sub and arithmetic shifts
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;
  localparam logic [5:0] funct6_base = 6'b000000;
  localparam logic [5:0] funct6_alt  = 6'b010000;

  typedef enum logic [5:0] {
    op_illegal,
    // upper immediate and jumps
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    // branches
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu,
    // loads
    op_lb,
    op_lh,
    op_lw,
    op_ld,
    op_lbu,
    op_lhu,
    op_lwu,
    // stores
    op_sb,
    op_sh,
    op_sw,
    op_sd,
    // register-immediate
    op_addi,
    op_slti,
    op_sltiu,
    op_xori,
    op_ori,
    op_andi,
    op_slli,
    op_srli,
    op_srai,
    // register-register
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    // 32-bit word ops
    op_addiw,
    op_slliw,
    op_srliw,
    op_sraiw,
    op_addw,
    op_subw,
    op_sllw,
    op_srlw,
    op_sraw
  } inst_op_e;

  typedef enum logic [2:0] {
    fmt_none,
    fmt_i,
    fmt_r,
    fmt_b,
    fmt_j,
    fmt_u,
    fmt_s
  } inst_fmt_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [ilen-1:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [ilen-1:0]       inst;
    inst_op_e              op;
    inst_fmt_e             fmt;
    logic                  rs1_en;
    logic [reg_addr_w-1:0] rs1_addr;
    logic                  rs2_en;
    logic [reg_addr_w-1:0] rs2_addr;
    logic                  rd_en;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       imm;
  } dec_pkt_t;

endpackage

// ==== rv_imm_gen.sv ====
module rv_imm_gen (
  input  logic [rv_decode_pkg::ilen-1:0] inst,
  input  rv_decode_pkg::inst_fmt_e       fmt,
  output logic [rv_decode_pkg::xlen-1:0] imm
);
  import rv_decode_pkg::*;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_u;

  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};

  // branch and jump offsets are halfword aligned
  assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};
  assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  // upper 20 bits, sign extended past bit 31 on rv64
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};

  always_comb begin
    case (fmt)
      fmt_i:   imm = imm_i;
      fmt_s:   imm = imm_s;
      fmt_b:   imm = imm_b;
      fmt_j:   imm = imm_j;
      fmt_u:   imm = imm_u;
      default: imm = '0;
    endcase
  end

endmodule

// ==== rv_inst_decode.sv ====
module rv_inst_decode (
  input  rv_decode_pkg::fetch_pkt_t in_pkt,
  output rv_decode_pkg::dec_pkt_t   dec_pkt
);
  import rv_decode_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [5:0]      funct6;
  inst_op_e        op;
  inst_fmt_e       fmt;
  logic [xlen-1:0] imm;

  assign opcode = in_pkt.inst[6:0];
  assign funct3 = in_pkt.inst[14:12];
  assign funct7 = in_pkt.inst[31:25];
  // rv64 shift amounts use bit 25, so only funct6 is fixed
  assign funct6 = in_pkt.inst[31:26];

  // operation select
  always_comb begin
    op = op_illegal;
    case (opcode)
      opc_lui:   op = op_lui;
      opc_auipc: op = op_auipc;
      opc_jal:   op = op_jal;
      opc_jalr: begin
        if (funct3 == 3'b000) begin
          op = op_jalr;
        end
      end
      opc_branch: begin
        case (funct3)
          3'b000:  op = op_beq;
          3'b001:  op = op_bne;
          3'b100:  op = op_blt;
          3'b101:  op = op_bge;
          3'b110:  op = op_bltu;
          3'b111:  op = op_bgeu;
          default: op = op_illegal;
        endcase
      end
      opc_load: begin
        case (funct3)
          3'b000:  op = op_lb;
          3'b001:  op = op_lh;
          3'b010:  op = op_lw;
          3'b011:  op = op_ld;
          3'b100:  op = op_lbu;
          3'b101:  op = op_lhu;
          3'b110:  op = op_lwu;
          default: op = op_illegal;
        endcase
      end
      opc_store: begin
        case (funct3)
          3'b000:  op = op_sb;
          3'b001:  op = op_sh;
          3'b010:  op = op_sw;
          3'b011:  op = op_sd;
          default: op = op_illegal;
        endcase
      end
      opc_op_imm: begin
        case (funct3)
          3'b000: op = op_addi;
          3'b010: op = op_slti;
          3'b011: op = op_sltiu;
          3'b100: op = op_xori;
          3'b110: op = op_ori;
          3'b111: op = op_andi;
          3'b001: begin
            if (funct6 == funct6_base) begin
              op = op_slli;
            end
          end
          default: begin
            if (funct6 == funct6_base) begin
              op = op_srli;
            end else if (funct6 == funct6_alt) begin
              op = op_srai;
            end
          end
        endcase
      end
      opc_op_imm32: begin
        case (funct3)
          3'b000: op = op_addiw;
          3'b001: begin
            if (funct7 == funct7_base) begin
              op = op_slliw;
            end
          end
          3'b101: begin
            if (funct7 == funct7_base) begin
              op = op_srliw;
            end else if (funct7 == funct7_alt) begin
              op = op_sraiw;
            end
          end
          default: op = op_illegal;
        endcase
      end
      opc_op: begin
        // M extension (funct7 = 0000001) falls through as illegal
        if (funct7 == funct7_base) begin
          case (funct3)
            3'b000:  op = op_add;
            3'b001:  op = op_sll;
            3'b010:  op = op_slt;
            3'b011:  op = op_sltu;
            3'b100:  op = op_xor;
            3'b101:  op = op_srl;
            3'b110:  op = op_or;
            default: op = op_and;
          endcase
        end else if (funct7 == funct7_alt) begin
          if (funct3 == 3'b000) begin
            op = op_sub;
          end else if (funct3 == 3'b101) begin
            op = op_sra;
          end
        end
      end
      opc_op32: begin
        if (funct7 == funct7_base) begin
          case (funct3)
            3'b000:  op = op_addw;
            3'b001:  op = op_sllw;
            3'b101:  op = op_srlw;
            default: op = op_illegal;
          endcase
        end else if (funct7 == funct7_alt) begin
          if (funct3 == 3'b000) begin
            op = op_subw;
          end else if (funct3 == 3'b101) begin
            op = op_sraw;
          end
        end
      end
      default: op = op_illegal;
    endcase
  end

  // format follows the operation
  always_comb begin
    case (op)
      op_lui, op_auipc: fmt = fmt_u;
      op_jal:           fmt = fmt_j;
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: fmt = fmt_b;
      op_sb, op_sh, op_sw, op_sd: fmt = fmt_s;
      op_jalr, op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
      op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
      op_slli, op_srli, op_srai,
      op_addiw, op_slliw, op_srliw, op_sraiw: fmt = fmt_i;
      op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra,
      op_or, op_and, op_addw, op_subw, op_sllw, op_srlw, op_sraw: fmt = fmt_r;
      default:          fmt = fmt_none;
    endcase
  end

  rv_imm_gen u_rv_imm_gen (
    .inst (in_pkt.inst),
    .fmt  (fmt),
    .imm  (imm)
  );

  always_comb begin
    dec_pkt.pc       = in_pkt.pc;
    dec_pkt.inst     = in_pkt.inst;
    dec_pkt.op       = op;
    dec_pkt.fmt      = fmt;
    // addresses are raw fields, enables tell which ones are live
    dec_pkt.rs1_addr = in_pkt.inst[19:15];
    dec_pkt.rs2_addr = in_pkt.inst[24:20];
    dec_pkt.rd_addr  = in_pkt.inst[11:7];
    dec_pkt.imm      = imm;
    case (fmt)
      fmt_i: begin
        dec_pkt.rs1_en = 1'b1;
        dec_pkt.rs2_en = 1'b0;
        dec_pkt.rd_en  = 1'b1;
      end
      fmt_r: begin
        dec_pkt.rs1_en = 1'b1;
        dec_pkt.rs2_en = 1'b1;
        dec_pkt.rd_en  = 1'b1;
      end
      fmt_b, fmt_s: begin
        dec_pkt.rs1_en = 1'b1;
        dec_pkt.rs2_en = 1'b1;
        dec_pkt.rd_en  = 1'b0;
      end
      fmt_j, fmt_u: begin
        dec_pkt.rs1_en = 1'b0;
        dec_pkt.rs2_en = 1'b0;
        dec_pkt.rd_en  = 1'b1;
      end
      default: begin
        dec_pkt.rs1_en = 1'b0;
        dec_pkt.rs2_en = 1'b0;
        dec_pkt.rd_en  = 1'b0;
      end
    endcase
  end

endmodule

// ==== ifid_stage_reg.sv ====
module ifid_stage_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  rv_decode_pkg::dec_pkt_t in_pkt,
  output logic                    out_valid,
  input  logic                    out_ready,
  output rv_decode_pkg::dec_pkt_t out_pkt
);
  import rv_decode_pkg::*;

  logic     valid_q;
  dec_pkt_t pkt_q;
  logic     load;

  // accept when empty or draining this cycle, never during flush
  assign in_ready = !flush && (!valid_q || out_ready);
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready) begin
      valid_q <= 1'b0;
    end
  end

  // payload only moves on an accepted beat, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (load) begin
      pkt_q <= in_pkt;
    end
  end

  assign out_valid = valid_q;
  assign out_pkt   = pkt_q;

endmodule

// ==== ifid_decode_top.sv ====
module ifid_decode_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  rv_decode_pkg::fetch_pkt_t in_pkt,
  output logic                      out_valid,
  input  logic                      out_ready,
  output rv_decode_pkg::dec_pkt_t   out_pkt
);
  import rv_decode_pkg::*;

  // decoded view of the incoming fetch packet
  dec_pkt_t dec_pkt;

  rv_inst_decode u_rv_inst_decode (
    .in_pkt  (in_pkt),
    .dec_pkt (dec_pkt)
  );

  ifid_stage_reg u_ifid_stage_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_pkt    (dec_pkt),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pkt   (out_pkt)
  );

endmodule

// ==== ifid_properties.sv ====
module ifid_properties (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    flush,
  input logic                    in_ready,
  input logic                    out_valid,
  input logic                    out_ready,
  input rv_decode_pkg::dec_pkt_t out_pkt
);
  timeunit 1ns;
  timeprecision 100ps;

  // stalled output must not move
  hold_under_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready && !flush |=> $stable(out_pkt)
  ) else $error("out_pkt changed while the consumer stalled");

  flush_empties: assert property (
    @(posedge clk) disable iff (!rst_n)
    flush |=> !out_valid
  ) else $error("out_valid still high after a flush");

  no_accept_on_flush: assert property (
    @(posedge clk) flush |-> !in_ready
  ) else $error("in_ready high during a flush");

  empty_in_reset: assert property (
    @(posedge clk) !rst_n |-> !out_valid
  ) else $error("out_valid high during reset");

endmodule

bind ifid_stage_reg ifid_properties u_ifid_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .flush     (flush),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_pkt   (out_pkt)
);

// ==== tb_ifid_decode.sv ====
module tb_ifid_decode;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_decode_pkg::*;

  localparam int num_beats  = 400;
  localparam int clk_period = 40;

  logic       clk;
  logic       rst_n;
  logic       flush;
  logic       in_valid;
  logic       in_ready;
  fetch_pkt_t in_pkt;
  logic       out_valid;
  logic       out_ready;
  dec_pkt_t   out_pkt;

  logic [31:0] lfsr_q = 32'h68814b8e;
  logic [63:0] pc_q;
  dec_pkt_t    exp_q[$];
  logic        took_in = 1'b0;
  logic        exp_valid = 1'b0;
  int          offered;
  int          in_count;
  int          out_count;
  int          dropped;

  // major opcodes the generator picks from
  logic [6:0] opcodes [11] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03,
                               7'h23, 7'h13, 7'h1b, 7'h33, 7'h3b};
  // lookup by funct3
  inst_op_e br_ops [8] = '{op_beq, op_bne, op_illegal, op_illegal,
                           op_blt, op_bge, op_bltu, op_bgeu};
  inst_op_e ld_ops [8] = '{op_lb, op_lh, op_lw, op_ld,
                           op_lbu, op_lhu, op_lwu, op_illegal};
  inst_op_e st_ops [8] = '{op_sb, op_sh, op_sw, op_sd,
                           op_illegal, op_illegal, op_illegal, op_illegal};
  inst_op_e imm_ops [8] = '{op_addi, op_illegal, op_slti, op_sltiu,
                            op_xori, op_illegal, op_ori, op_andi};
  inst_op_e reg_ops [8] = '{op_add, op_sll, op_slt, op_sltu,
                            op_xor, op_srl, op_or, op_and};
  inst_op_e word_ops [8] = '{op_addw, op_sllw, op_illegal, op_illegal,
                             op_illegal, op_srlw, op_illegal, op_illegal};

  ifid_decode_top u_ifid_decode_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_pkt    (in_pkt),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pkt   (out_pkt)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] make_inst();
    logic [31:0] w;
    logic [3:0]  idx;
    w = take_bits(32);
    // one word in eight stays fully random
    if (take_bits(3) != 0) begin
      idx      = 4'(take_bits(4) % 11);
      w[6:0]   = opcodes[idx];
      case (2'(take_bits(2)))
        2'd0:    w[31:26] = 6'b000000;
        2'd1:    w[31:26] = 6'b010000;
        2'd2:    w[31:25] = 7'b0000001;
        default: ;
      endcase
    end
    return w;
  endfunction

  function automatic dec_pkt_t model_decode(input fetch_pkt_t f);
    dec_pkt_t    d;
    logic [31:0] i;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        alt;
    logic [2:0]  en;
    inst_op_e    op;
    inst_fmt_e   fmt;
    i   = f.inst;
    f3  = i[14:12];
    f7  = i[31:25];
    alt = (f7 == 7'b0100000);
    case (i[6:0])
      7'b0110111: op = op_lui;
      7'b0010111: op = op_auipc;
      7'b1101111: op = op_jal;
      7'b1100111: op = (f3 == 3'd0) ? op_jalr : op_illegal;
      7'b1100011: op = br_ops[f3];
      7'b0000011: op = ld_ops[f3];
      7'b0100011: op = st_ops[f3];
      7'b0010011: begin
        case (f3)
          3'd1:    op = (i[31:26] == 6'd0) ? op_slli : op_illegal;
          3'd5:    op = (i[31:26] == 6'd0) ? op_srli :
                        (i[31:26] == 6'b010000) ? op_srai : op_illegal;
          default: op = imm_ops[f3];
        endcase
      end
      7'b0011011: begin
        case (f3)
          3'd0:    op = op_addiw;
          3'd1:    op = (f7 == 7'd0) ? op_slliw : op_illegal;
          3'd5:    op = (f7 == 7'd0) ? op_srliw : alt ? op_sraiw : op_illegal;
          default: op = op_illegal;
        endcase
      end
      7'b0110011: op = (f7 == 7'd0) ? reg_ops[f3] : (alt && f3 == 3'd0) ? op_sub :
                       (alt && f3 == 3'd5) ? op_sra : op_illegal;
      7'b0111011: op = (f7 == 7'd0) ? word_ops[f3] : (alt && f3 == 3'd0) ? op_subw :
                       (alt && f3 == 3'd5) ? op_sraw : op_illegal;
      default:    op = op_illegal;
    endcase
    case (i[6:0])
      7'b0110111, 7'b0010111: fmt = fmt_u;
      7'b1101111:             fmt = fmt_j;
      7'b1100011:             fmt = fmt_b;
      7'b0100011:             fmt = fmt_s;
      7'b0110011, 7'b0111011: fmt = fmt_r;
      default:                fmt = fmt_i;
    endcase
    d.pc   = f.pc;
    d.inst = i;
    d.op   = op;
    d.fmt  = (op == op_illegal) ? fmt_none : fmt;
    case (d.fmt)
      fmt_i:        en = 3'b101;
      fmt_r:        en = 3'b111;
      fmt_b, fmt_s: en = 3'b110;
      fmt_j, fmt_u: en = 3'b001;
      default:      en = 3'b000;
    endcase
    {d.rs1_en, d.rs2_en, d.rd_en} = en;
    d.rs1_addr = i[19:15];
    d.rs2_addr = i[24:20];
    d.rd_addr  = i[11:7];
    case (d.fmt)
      fmt_i:   d.imm = 64'($signed(i[31:20]));
      fmt_s:   d.imm = 64'($signed({i[31:25], i[11:7]}));
      fmt_b:   d.imm = 64'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
      fmt_j:   d.imm = 64'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
      fmt_u:   d.imm = 64'($signed({i[31:12], 12'h000}));
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_dec_pkt(input dec_pkt_t got, input dec_pkt_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: inst %h pc %h got %s %s en %b imm %h rd %0d",
                          $time, exp.inst, exp.pc, got.op.name(), got.fmt.name(),
                          {got.rs1_en, got.rs2_en, got.rd_en}, got.imm, got.rd_addr));
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic drive_step();
    // hold the offered beat until it is taken
    if (!in_valid || took_in) begin
      in_valid = (offered < num_beats) && (take_bits(2) != 0);
      if (in_valid) begin
        in_pkt.pc   = pc_q;
        in_pkt.inst = make_inst();
        pc_q        = pc_q + 64'd4;
        offered++;
      end
    end
    out_ready = (take_bits(2) != 0);
    flush     = (take_bits(5) == 0);
  endtask

  // mid-cycle sample, acting for the next rising edge
  always @(negedge clk) begin
    took_in = 1'b0;
    if (rst_n) begin
      // one-entry occupancy, output one cycle after accept
      compare_flag(out_valid, exp_valid, "out_valid");
      compare_flag(in_ready, !flush && (!exp_valid || out_ready), "in_ready");
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          abort_run($sformatf("error at %0t: output pc %h with nothing expected",
                              $time, out_pkt.pc));
        end else begin
          compare_dec_pkt(out_pkt, exp_q.pop_front());
        end
        out_count++;
      end
      if (flush) begin
        dropped += exp_q.size();
        exp_q.delete();
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(model_decode(in_pkt));
        in_count++;
        took_in = 1'b1;
      end
      // a held entry stays unless it drains or is flushed
      exp_valid = took_in || (exp_valid && !out_ready && !flush);
    end
  end

  initial begin
    rst_n     = 1'b0;
    flush     = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    in_pkt    = '0;
    pc_q      = 64'h0000_0000_8000_0000;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    @(negedge clk);
    compare_flag(out_valid, 1'b0, "out_valid after reset");
    compare_flag(in_ready, 1'b1, "in_ready after reset");
    while (in_count < num_beats) begin
      @(posedge clk);
      #2;
      drive_step();
    end
    // drain the stage register
    @(posedge clk);
    #2;
    flush     = 1'b0;
    out_ready = 1'b1;
    @(negedge clk);
    while (out_valid) begin
      @(negedge clk);
    end
    compare_count(out_count, in_count - dropped, "output transfers");
    compare_count(exp_q.size(), 0, "packets still expected");
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(num_beats * clk_period * 10);
    abort_run($sformatf("timeout: run still going after %0d ns",
                        num_beats * clk_period * 10));
  end

endmodule

// ==== tb.f ====
rv_decode_pkg.sv
rv_imm_gen.sv
rv_inst_decode.sv
ifid_stage_reg.sv
ifid_decode_top.sv
ifid_properties.sv
tb_ifid_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, then run; the exit status follows the simulation
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_ifid_decode -f tb.f -o tb_ifid_decode_sim \
  && ./obj_dir/tb_ifid_decode_sim \
  || exit 1
